//--- logic/rec_csr_pkg.sv
// Recovery register word types, register indices and register contents shared by the executor
`default_nettype none

package rec_csr_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [7:0]  byte_t;

  typedef enum logic [3:0] {
    CSR_PROT_CAP_0      = 4'd0,
    CSR_PROT_CAP_1      = 4'd1,
    CSR_PROT_CAP_2      = 4'd2,
    CSR_PROT_CAP_3      = 4'd3,
    CSR_DEVICE_STATUS_0 = 4'd4,
    CSR_DEVICE_STATUS_1 = 4'd5,
    CSR_DEVICE_RESET    = 4'd6,
    CSR_RECOVERY_CTRL   = 4'd7,
    CSR_RECOVERY_STATUS = 4'd8,
    CSR_HW_STATUS       = 4'd9,
    CSR_INVALID         = 4'd15
  } csr_idx_e;

  // Read-only words supplied from outside, 224 bits
  typedef struct packed {
    csr_word_t prot_cap_0;
    csr_word_t prot_cap_1;
    csr_word_t prot_cap_2;
    csr_word_t prot_cap_3;
    csr_word_t device_status_1;
    csr_word_t recovery_status;
    csr_word_t hw_status;
  } csr_ro_t;

  // Device status word 0, byte 1 holds the protocol status
  typedef struct packed {
    logic [15:0] reason;
    logic [7:0]  protocol;
    logic [7:0]  device;
  } dev_status_0_t;

endpackage

`default_nettype wire

//--- logic/rec_cmd_pkg.sv
// Recovery command codes, protocol status codes, FSM phase and the command to register map
`default_nettype none

package rec_cmd_pkg;
  import rec_csr_pkg::*;

  typedef enum logic [7:0] {
    CMD_PROT_CAP        = 8'd34,
    CMD_DEVICE_STATUS   = 8'd36,
    CMD_DEVICE_RESET    = 8'd37,
    CMD_RECOVERY_CTRL   = 8'd38,
    CMD_RECOVERY_STATUS = 8'd39,
    CMD_HW_STATUS       = 8'd40
  } rec_cmd_e;

  typedef enum logic [7:0] {
    PROTO_OK        = 8'h00,
    PROTO_READ_ONLY = 8'h01,
    PROTO_PARAMETER = 8'h02,
    PROTO_LENGTH    = 8'h03,
    PROTO_CRC       = 8'h04
  } rec_proto_err_e;

  // Response length in bytes as seen by the register map
  typedef logic [11:0] map_len_t;

  typedef struct packed {
    csr_idx_e   idx;
    logic [3:0] words;
    map_len_t   len;
  } rec_map_t;

  // One bit per executor phase, at most one set
  typedef struct packed {
    logic load;
    logic write;
    logic rd_len;
    logic rd_data;
    logic fail;
    logic done;
  } rec_phase_t;

  function automatic rec_map_t rec_map(logic [7:0] cmd);
    rec_map_t m;
    // Unknown commands read four zero bytes and take no words
    m = '{idx: CSR_INVALID, words: 4'd0, len: 12'd4};
    case (cmd)
      CMD_PROT_CAP:        m = '{idx: CSR_PROT_CAP_0, words: 4'd4, len: 12'd15};
      CMD_DEVICE_STATUS:   m = '{idx: CSR_DEVICE_STATUS_0, words: 4'd2, len: 12'd8};
      CMD_DEVICE_RESET:    m = '{idx: CSR_DEVICE_RESET, words: 4'd1, len: 12'd3};
      CMD_RECOVERY_CTRL:   m = '{idx: CSR_RECOVERY_CTRL, words: 4'd1, len: 12'd3};
      CMD_RECOVERY_STATUS: m = '{idx: CSR_RECOVERY_STATUS, words: 4'd1, len: 12'd2};
      CMD_HW_STATUS:       m = '{idx: CSR_HW_STATUS, words: 4'd1, len: 12'd4};
      default: ;
    endcase
    return m;
  endfunction

endpackage

`default_nettype wire

//--- logic/rec_exec_fsm.sv
// Command FSM of the recovery executor, sequences writes, reads and errored commands
`timescale 1ns/10ps
`default_nettype none

module rec_exec_fsm import rec_cmd_pkg::*; #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmd_valid_i,
  input  logic                cmd_is_rd_i,
  input  logic                cmd_error_i,
  input  logic [LenWidth-1:0] cmd_len_i,
  input  logic                last_word_i,
  input  logic                last_byte_i,
  input  logic                rx_ack_i,
  input  logic                res_ready_i,
  input  logic                res_dready_i,
  output rec_phase_t          phase_o,
  output logic                rx_req_o,
  output logic                cmd_done_o,
  output logic                rx_queue_clr_o,
  output logic                res_dvalid_o
);

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    CsrRead,
    CsrReadLen,
    CsrReadData,
    Error,
    Done
  } state_e;

  state_e state_q, state_d;
  logic   wr_fin_q;
  logic   rx_req_q;
  logic   accept_wr;

  assign phase_o.load    = (state_q == Idle) & cmd_valid_i;
  assign phase_o.write   = (state_q == CsrWrite);
  assign phase_o.rd_len  = (state_q == CsrReadLen);
  assign phase_o.rd_data = (state_q == CsrReadData);
  assign phase_o.fail    = (state_q == Error);
  assign phase_o.done    = (state_q == Done);

  assign accept_wr = phase_o.load & ~cmd_error_i & ~cmd_is_rd_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_error_i) state_d = Error;
          else if (cmd_is_rd_i) state_d = CsrRead;
          else state_d = CsrWrite;
        end
      end
      // A zero-length write passes through with wr_fin_q already set
      CsrWrite:    if (wr_fin_q) state_d = Done;
      CsrRead:     if (res_ready_i) state_d = CsrReadLen;
      CsrReadLen:  state_d = CsrReadData;
      CsrReadData: if (res_dready_i && last_byte_i) state_d = Done;
      Error:       state_d = Done;
      Done:        state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      wr_fin_q <= 1'b0;
      rx_req_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // First word asked on accept, the next one after each ack but the last
      rx_req_q <= (accept_wr & (cmd_len_i != '0)) | (phase_o.write & rx_ack_i & ~last_word_i);
      if (phase_o.load) wr_fin_q <= (cmd_len_i == '0);
      else if (phase_o.write && rx_ack_i && last_word_i) wr_fin_q <= 1'b1;
    end
  end

  assign rx_req_o       = rx_req_q;
  assign cmd_done_o     = phase_o.done;
  assign rx_queue_clr_o = phase_o.fail;
  assign res_dvalid_o   = phase_o.rd_data;

  a_done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o |=> !cmd_done_o);

  a_req_in_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_req_o |-> state_q == CsrWrite);

endmodule

`default_nettype wire

//--- logic/rec_xfer_counter.sv
// Remaining word and byte counter with byte lane for recovery transfers
`timescale 1ns/10ps
`default_nettype none

module rec_xfer_counter import rec_cmd_pkg::*; #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rec_phase_t          phase_i,
  input  logic [LenWidth-1:0] cmd_len_i,
  input  map_len_t            map_len_i,
  input  logic                rx_ack_i,
  input  logic                res_dready_i,
  output logic                last_word_o,
  output logic [1:0]          lane_o,
  output logic                last_byte_o,
  output logic                word_step_o
);

  logic [LenWidth-1:0] cnt_q;
  logic [1:0]          lane_q;
  logic                byte_hs;
  logic                dec;

  assign byte_hs = phase_i.rd_data & res_dready_i;
  assign dec     = (phase_i.write & rx_ack_i) | byte_hs;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      lane_q <= 2'd0;
    end else if (phase_i.load) begin
      // Words in the write, length rounded up to whole words
      cnt_q  <= LenWidth'(cmd_len_i[LenWidth-1:2]) + LenWidth'(|cmd_len_i[1:0]);
      lane_q <= 2'd0;
    end else if (phase_i.rd_len) begin
      cnt_q  <= LenWidth'(map_len_i);
      lane_q <= 2'd0;
    end else if (dec) begin
      cnt_q <= cnt_q - 1'b1;
      if (byte_hs) lane_q <= lane_q + 2'd1;
    end
  end

  assign last_word_o = phase_i.write & (cnt_q == LenWidth'(1));
  assign last_byte_o = phase_i.rd_data & (cnt_q == LenWidth'(1));
  assign lane_o      = lane_q;
  assign word_step_o = byte_hs & (lane_q == 2'd3);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec |-> cnt_q != '0);

endmodule

`default_nettype wire

//--- logic/rec_csr_bank.sv
// Writable recovery registers, register pointer and read word multiplexer of the executor
`timescale 1ns/10ps
`default_nettype none

module rec_csr_bank import rec_cmd_pkg::*, rec_csr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  rec_phase_t phase_i,
  input  logic [7:0] cmd_cmd_i,
  input  logic       cmd_error_i,
  input  logic       cmd_valid_i,
  input  logic       rx_ack_i,
  input  csr_word_t  rx_data_i,
  input  logic       word_step_i,
  input  csr_ro_t    ro_regs_i,
  output csr_word_t  rd_word_o,
  output map_len_t   map_len_o,
  output logic       image_activated_o
);

  rec_map_t      cmd_map;
  csr_idx_e      ptr_q;
  logic [3:0]    left_q;
  map_len_t      map_len_q;
  logic          err_q;
  csr_word_t     device_reset_q;
  csr_word_t     recovery_ctrl_q;
  dev_status_0_t status_q;
  logic          wr_ack;
  logic          in_range;
  logic          wr_en;
  logic          step;

  assign cmd_map  = rec_map(cmd_cmd_i);
  assign wr_ack   = phase_i.write & rx_ack_i;
  assign in_range = (left_q != 4'd0);
  assign wr_en    = wr_ack & in_range;
  // Pointer stops at the end of the register range, extra words are dropped
  assign step     = (wr_ack | word_step_i) & in_range;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q     <= CSR_INVALID;
      left_q    <= 4'd0;
      map_len_q <= '0;
      err_q     <= 1'b0;
    end else if (phase_i.load) begin
      ptr_q     <= cmd_map.idx;
      left_q    <= cmd_map.words;
      map_len_q <= cmd_map.len;
      err_q     <= cmd_valid_i & cmd_error_i;
    end else if (step) begin
      ptr_q  <= csr_idx_e'(ptr_q + 4'd1);
      left_q <= left_q - 4'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
      status_q        <= '0;
    end else begin
      if (wr_en && ptr_q == CSR_DEVICE_RESET) device_reset_q <= rx_data_i;
      if (wr_en && ptr_q == CSR_RECOVERY_CTRL) recovery_ctrl_q <= rx_data_i;
      // Protocol status of the command that just finished
      if (phase_i.done) status_q.protocol <= err_q ? PROTO_CRC : PROTO_OK;
    end
  end

  always_comb begin
    unique case (ptr_q)
      CSR_PROT_CAP_0:      rd_word_o = ro_regs_i.prot_cap_0;
      CSR_PROT_CAP_1:      rd_word_o = ro_regs_i.prot_cap_1;
      CSR_PROT_CAP_2:      rd_word_o = ro_regs_i.prot_cap_2;
      CSR_PROT_CAP_3:      rd_word_o = ro_regs_i.prot_cap_3;
      CSR_DEVICE_STATUS_0: rd_word_o = status_q;
      CSR_DEVICE_STATUS_1: rd_word_o = ro_regs_i.device_status_1;
      CSR_DEVICE_RESET:    rd_word_o = device_reset_q;
      CSR_RECOVERY_CTRL:   rd_word_o = recovery_ctrl_q;
      CSR_RECOVERY_STATUS: rd_word_o = ro_regs_i.recovery_status;
      CSR_HW_STATUS:       rd_word_o = ro_regs_i.hw_status;
      default:             rd_word_o = '0;
    endcase
  end

  assign map_len_o         = map_len_q;
  assign image_activated_o = (recovery_ctrl_q[23:16] == 8'h0F);

  // An in-range write word never lands beyond the registers of the map
  a_wr_in_map: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> ptr_q inside {[CSR_PROT_CAP_0:CSR_HW_STATUS]});

endmodule

`default_nettype wire

//--- logic/rec_resp_tx.sv
// Response length strobe and byte serializer of the recovery executor
`timescale 1ns/10ps
`default_nettype none

module rec_resp_tx import rec_cmd_pkg::*, rec_csr_pkg::*; #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rec_phase_t          phase_i,
  input  logic                res_ready_i,
  input  csr_word_t           rd_word_i,
  input  logic [1:0]          lane_i,
  input  logic                last_byte_i,
  input  map_len_t            map_len_i,
  output logic                res_valid_o,
  output logic [LenWidth-1:0] res_len_o,
  output byte_t               res_data_o,
  output logic                res_dlast_o
);

  logic res_valid_q;

  // Length strobe one edge after the length phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= phase_i.rd_len & res_ready_i;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_len_o   = LenWidth'(map_len_i);

  // LSB first
  assign res_data_o  = rd_word_i[{lane_i, 3'b000} +: 8];
  assign res_dlast_o = phase_i.rd_data & last_byte_i;

endmodule

`default_nettype wire

//--- logic/recovery_executor.sv
// Top level of the I3C recovery command executor, instantiated by the target datapath
`timescale 1ns/10ps
`default_nettype none

module recovery_executor import rec_cmd_pkg::*, rec_csr_pkg::*; #(
  parameter int unsigned LenWidth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Command from the receiver
  input  logic                cmd_valid_i,
  input  logic                cmd_is_rd_i,
  input  logic [7:0]          cmd_cmd_i,
  input  logic [LenWidth-1:0] cmd_len_i,
  input  logic                cmd_error_i,
  output logic                cmd_done_o,
  // Response
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [LenWidth-1:0] res_len_o,
  output logic                res_dvalid_o,
  input  logic                res_dready_i,
  output byte_t               res_data_o,
  output logic                res_dlast_o,
  // Receive queue
  output logic                rx_req_o,
  input  logic                rx_ack_i,
  input  csr_word_t           rx_data_i,
  output logic                rx_queue_clr_o,
  // Registers
  input  csr_ro_t             ro_regs_i,
  output logic                image_activated_o
);

  rec_phase_t phase;
  logic       last_word;
  logic       last_byte;
  logic       word_step;
  logic [1:0] lane;
  csr_word_t  rd_word;
  map_len_t   map_len;

  rec_exec_fsm #(.LenWidth(LenWidth)) rec_exec_fsm_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_is_rd_i, .cmd_error_i, .cmd_len_i,
    .last_word_i    (last_word),
    .last_byte_i    (last_byte),
    .rx_ack_i, .res_ready_i, .res_dready_i,
    .phase_o        (phase),
    .rx_req_o, .cmd_done_o, .rx_queue_clr_o, .res_dvalid_o
  );

  rec_xfer_counter #(.LenWidth(LenWidth)) rec_xfer_counter_i (
    .clk_i, .rst_ni,
    .phase_i        (phase),
    .cmd_len_i,
    .map_len_i      (map_len),
    .rx_ack_i, .res_dready_i,
    .last_word_o    (last_word),
    .lane_o         (lane),
    .last_byte_o    (last_byte),
    .word_step_o    (word_step)
  );

  rec_csr_bank rec_csr_bank_i (
    .clk_i, .rst_ni,
    .phase_i        (phase),
    .cmd_cmd_i, .cmd_error_i, .cmd_valid_i, .rx_ack_i, .rx_data_i,
    .word_step_i    (word_step),
    .ro_regs_i,
    .rd_word_o      (rd_word),
    .map_len_o      (map_len),
    .image_activated_o
  );

  rec_resp_tx #(.LenWidth(LenWidth)) rec_resp_tx_i (
    .clk_i, .rst_ni,
    .phase_i        (phase),
    .res_ready_i,
    .rd_word_i      (rd_word),
    .lane_i         (lane),
    .last_byte_i    (last_byte),
    .map_len_i      (map_len),
    .res_valid_o, .res_len_o, .res_data_o, .res_dlast_o
  );

endmodule

`default_nettype wire

//--- test/tb_recovery_executor.sv
// Testbench of the recovery executor, replays the command trace and checks responses and flags
`timescale 1ns/10ps
`default_nettype none

module tb_recovery_executor import rec_cmd_pkg::*, rec_csr_pkg::*; ();

  localparam int unsigned LenWidth      = 16;
  localparam int unsigned MaxLines      = 20;
  localparam int unsigned LineWords     = 7;
  localparam int unsigned CyclesPerLine = 200;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                cmd_valid_i;
  logic                cmd_is_rd_i;
  logic [7:0]          cmd_cmd_i;
  logic [LenWidth-1:0] cmd_len_i;
  logic                cmd_error_i;
  logic                cmd_done_o;
  logic                res_valid_o;
  logic                res_ready_i;
  logic [LenWidth-1:0] res_len_o;
  logic                res_dvalid_o;
  logic                res_dready_i;
  byte_t               res_data_o;
  logic                res_dlast_o;
  logic                rx_req_o;
  logic                rx_ack_i;
  csr_word_t           rx_data_i;
  logic                rx_queue_clr_o;
  csr_ro_t             ro_regs_i;
  logic                image_activated_o;

  csr_word_t   trace_mem [MaxLines*LineWords];
  csr_word_t   wr_words [$];
  csr_word_t   model_ctrl;
  integer      seed = 342;
  int unsigned cyc = 0;
  int unsigned acc_cyc;
  int unsigned req_count;
  int unsigned err_cnt;
  int unsigned n_tests;
  int unsigned n_failed;
  logic        trace_ready = 1'b0;

  recovery_executor #(.LenWidth(LenWidth)) recovery_executor_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_is_rd_i, .cmd_cmd_i, .cmd_len_i, .cmd_error_i,
    .cmd_done_o, .res_valid_o, .res_ready_i, .res_len_o, .res_dvalid_o, .res_dready_i,
    .res_data_o, .res_dlast_o, .rx_req_o, .rx_ack_i, .rx_data_i, .rx_queue_clr_o,
    .ro_regs_i, .image_activated_o
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s: got 0x%h, expected 0x%h", sig, got, exp);
    err_cnt++;
  endtask

  task automatic raise_failure(input string what);
    $display("%s", what);
    err_cnt++;
  endtask

  function automatic string op_label(input csr_word_t op);
    case (op)
      32'd1:   return "write";
      32'd2:   return "read";
      32'd3:   return "error";
      default: return "unknown";
    endcase
  endfunction

  // Expected response byte, LSB first across the trace words
  function automatic byte_t exp_byte(input int unsigned base, input int unsigned idx);
    csr_word_t w;
    w = (idx < 16) ? trace_mem[base + 3 + idx / 4] : '0;
    return w[8 * (idx % 4) +: 8];
  endfunction

  task automatic send_cmd(input logic is_rd, input logic err, input logic [7:0] cmd,
                          input logic [LenWidth-1:0] len);
    cmd_valid_i = 1'b1;
    cmd_is_rd_i = is_rd;
    cmd_error_i = err;
    cmd_cmd_i   = cmd;
    cmd_len_i   = len;
    @(posedge clk_i);
    acc_cyc = cyc;
    #1;
    cmd_valid_i = 1'b0;
    cmd_is_rd_i = 1'b0;
    cmd_error_i = 1'b0;
    cmd_cmd_i   = 8'h00;
    cmd_len_i   = '0;
  endtask

  task automatic apply_write(input int unsigned base);
    int unsigned n_words;
    int unsigned last_ack;
    int unsigned done_cyc;
    logic        fin;
    n_words = (trace_mem[base+2] + 3) / 4;
    for (int unsigned i = 0; i < n_words; i++)
      wr_words.push_back(trace_mem[base+3+i]);
    req_count = 0;
    send_cmd(1'b0, 1'b0, trace_mem[base+1][7:0], LenWidth'(trace_mem[base+2]));
    last_ack = acc_cyc;
    fin = 1'b0;
    while (!fin) begin
      @(posedge clk_i);
      if (rx_ack_i) last_ack = cyc;
      fin = cmd_done_o;
      done_cyc = cyc;
    end
    #1;
    assert (req_count == n_words) else report_mismatch("rx_req_o count", req_count, n_words);
    assert (done_cyc == last_ack + 2)
      else report_mismatch("cmd_done_o delay", done_cyc - last_ack, 2);
    wr_words.delete();
    // Only the first word lands in a one-word register
    if (trace_mem[base+1][7:0] == CMD_RECOVERY_CTRL && n_words != 0)
      model_ctrl = trace_mem[base+3];
  endtask

  task automatic collect_read(input int unsigned base);
    int unsigned exp_len;
    int unsigned n_bytes;
    int unsigned n_len;
    int unsigned waited;
    int unsigned last_hs;
    int unsigned done_cyc;
    logic        fin;
    exp_len = trace_mem[base+2];
    n_bytes = 0;
    n_len   = 0;
    waited  = 0;
    last_hs = 0;
    req_count = 0;
    send_cmd(1'b1, 1'b0, trace_mem[base+1][7:0], LenWidth'(exp_len));
    fin = 1'b0;
    while (!fin) begin
      // Hold off the length for two cycles, then random back-pressure on data
      res_ready_i  = (waited >= 2);
      res_dready_i = ({$random(seed)} % 2) != 0;
      @(posedge clk_i);
      waited++;
      if (res_valid_o) begin
        n_len++;
        assert (res_len_o == LenWidth'(exp_len))
          else report_mismatch("res_len_o", res_len_o, exp_len);
      end
      if (res_dvalid_o && res_dready_i) begin
        assert (n_len == 1) else raise_failure("Data byte sent without a single length strobe");
        assert (res_data_o == exp_byte(base, n_bytes))
          else report_mismatch("res_data_o", res_data_o, exp_byte(base, n_bytes));
        assert (res_dlast_o == (n_bytes + 1 == exp_len))
          else report_mismatch("res_dlast_o", res_dlast_o, n_bytes + 1 == exp_len);
        n_bytes++;
        last_hs = cyc;
      end
      fin = cmd_done_o;
      done_cyc = cyc;
      #1;
    end
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
    assert (n_len == 1) else report_mismatch("res_valid_o count", n_len, 1);
    assert (n_bytes == exp_len) else report_mismatch("byte count", n_bytes, exp_len);
    assert (done_cyc == last_hs + 1)
      else report_mismatch("cmd_done_o delay", done_cyc - last_hs, 1);
    assert (req_count == 0) else report_mismatch("rx_req_o count", req_count, 0);
  endtask

  task automatic inject_error(input int unsigned base);
    req_count = 0;
    send_cmd(1'b0, 1'b1, trace_mem[base+1][7:0], LenWidth'(trace_mem[base+2]));
    @(posedge clk_i);
    assert (rx_queue_clr_o == 1'b1)
      else report_mismatch("rx_queue_clr_o", rx_queue_clr_o, 1);
    assert (cmd_done_o == 1'b0) else report_mismatch("cmd_done_o", cmd_done_o, 0);
    @(posedge clk_i);
    assert (rx_queue_clr_o == 1'b0)
      else report_mismatch("rx_queue_clr_o", rx_queue_clr_o, 0);
    assert (cmd_done_o == 1'b1) else report_mismatch("cmd_done_o", cmd_done_o, 1);
    #1;
    assert (req_count == 0) else report_mismatch("rx_req_o count", req_count, 0);
  endtask

  // Receive queue, answers each request after 0 to 3 idle cycles
  initial begin : rx_queue_model
    int unsigned gap;
    forever begin
      @(posedge clk_i);
      if (rx_req_o) begin
        req_count++;
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk_i);
        #1;
        assert (wr_words.size() != 0)
          else raise_failure("Receive request with no word left to send");
        if (wr_words.size() != 0) rx_data_i = wr_words.pop_front();
        else rx_data_i = '0;
        rx_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        rx_ack_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (trace_ready);
    repeat ((n_tests + 1) * CyclesPerLine) @(posedge clk_i);
    $display("Timeout: the trace did not finish within %0d cycles", (n_tests + 1) * CyclesPerLine);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main_seq
    int unsigned base;
    int unsigned errs_before;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_is_rd_i  = 1'b0;
    cmd_cmd_i    = 8'h00;
    cmd_len_i    = '0;
    cmd_error_i  = 1'b0;
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
    rx_ack_i     = 1'b0;
    rx_data_i    = '0;
    ro_regs_i.prot_cap_0      = 32'h0403_0201;
    ro_regs_i.prot_cap_1      = 32'h0807_0605;
    ro_regs_i.prot_cap_2      = 32'h0C0B_0A09;
    ro_regs_i.prot_cap_3      = 32'h100F_0E0D;
    ro_regs_i.device_status_1 = 32'h5A5A_0001;
    ro_regs_i.recovery_status = 32'h0000_0311;
    ro_regs_i.hw_status       = 32'hCAFE_0042;
    model_ctrl = '0;
    err_cnt    = 0;
    n_failed   = 0;
    $readmemh("test/rec_trace.txt", trace_mem);
    n_tests = 0;
    while (n_tests < MaxLines && trace_mem[n_tests * LineWords] != 0)
      n_tests++;
    trace_ready = 1'b1;
    assert (n_tests != 0) else raise_failure("The trace file holds no tests");
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    assert ({cmd_done_o, rx_req_o, rx_queue_clr_o, res_valid_o, res_dvalid_o, res_dlast_o,
             image_activated_o} == '0)
      else report_mismatch("outputs after reset", {cmd_done_o, rx_req_o, rx_queue_clr_o,
                           res_valid_o, res_dvalid_o, res_dlast_o, image_activated_o}, 0);
    for (int unsigned t = 0; t < n_tests; t++) begin
      base = t * LineWords;
      errs_before = err_cnt;
      case (trace_mem[base])
        32'd1:   apply_write(base);
        32'd2:   collect_read(base);
        32'd3:   inject_error(base);
        default: raise_failure("Unknown opcode in the trace");
      endcase
      assert (image_activated_o == (model_ctrl[23:16] == 8'h0F))
        else report_mismatch("image_activated_o", image_activated_o,
                             model_ctrl[23:16] == 8'h0F);
      if (err_cnt != errs_before) n_failed++;
      $display("test %0d %s cmd 0x%h len %0d: %s", t, op_label(trace_mem[base]),
               trace_mem[base+1][7:0], trace_mem[base+2],
               (err_cnt == errs_before) ? "ok" : "failed");
    end
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/rec_trace.txt
// op (1 write, 2 read, 3 errored, 0 end), command, length, then four words
// Words are write data for op 1 and expected read words, LSB first, for op 2
1 26 4 00112233 0 0 0
2 26 3 00112233 0 0 0
1 26 4 000F0000 0 0 0
2 26 3 000F0000 0 0 0
1 26 4 00010000 0 0 0
2 22 F 04030201 08070605 0C0B0A09 100F0E0D
3 26 4 0 0 0 0
2 24 8 00000400 5A5A0001 0 0
2 24 8 00000000 5A5A0001 0 0
1 28 8 DEADBEEF 12345678 0 0
2 28 4 CAFE0042 0 0 0
1 26 0 0 0 0 0
2 26 3 00010000 0 0 0
1 26 8 000F0000 11111111 0 0
2 26 3 000F0000 0 0 0
2 30 4 0 0 0 0
2 27 2 00000311 0 0 0
1 25 4 00000055 0 0 0
2 25 3 00000055 0 0 0
0 0 0 0 0 0 0

//--- build.f
logic/rec_csr_pkg.sv
logic/rec_cmd_pkg.sv
logic/rec_exec_fsm.sv
logic/rec_xfer_counter.sv
logic/rec_csr_bank.sv
logic/rec_resp_tx.sv
logic/recovery_executor.sv
test/tb_recovery_executor.sv

//--- Bender.yml
package:
  name: recovery_executor

sources:
  - logic/rec_csr_pkg.sv
  - logic/rec_cmd_pkg.sv
  - logic/rec_exec_fsm.sv
  - logic/rec_xfer_counter.sv
  - logic/rec_csr_bank.sv
  - logic/rec_resp_tx.sv
  - logic/recovery_executor.sv
  - target: test
    files:
      - test/tb_recovery_executor.sv
